/* build.f */
miner_pkg.sv
run_control.sv
work_source.sv
perf_monitor.sv
miner_harness_top.sv
tb_clock.sv
harness_props.sv
tb_top.sv

/* Makefile */
# Verilator build, run, lint and clean for the miner harness

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module tb_top -o Vtb_top

run: build
	@out=$$(./obj_dir/Vtb_top +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module tb_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* tb_top.sv */
// module tb_top: testbench top with dut, random engine stimulus, timeout and final verdict
`default_nettype none
`timescale 1ns/1ps

module tb_top import miner_pkg::*; ();

  //////////////////////////////////////////////////
  // run length
  //////////////////////////////////////////////////

  localparam int RESET_CYCLES = 5;
  localparam int STIM_CYCLES  = 200;
  // reset, start latency, stimulus, exit drain, csr sweep, plus margin
  localparam int TIMEOUT      = RESET_CYCLES + 10 + STIM_CYCLES + 20 + 10 + 155;

  logic                  clk_slow;
  logic                  rst_n_c_slow;
  logic                  i_start;
  logic                  i_exit;
  logic                  o_busy;
  logic                  o_done;
  logic                  o_work_valid;
  logic                  i_work_ready;
  logic [BLOCK_W-1:0]    o_work_data;
  logic [NONCE_W-1:0]    o_work_nonce;
  logic                  i_result_valid;
  logic                  o_result_ready;
  logic [RESULT_W-1:0]   i_result_data;
  logic [CSR_ADDR_W-1:0] i_csr_addr;
  logic [CSR_W-1:0]      o_csr_rdata;
  int                    cycle_cnt;

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk_slow     (clk_slow),
    .rst_n_c_slow (rst_n_c_slow)
  );

  miner_harness_top dut (
    .clk_slow       (clk_slow),
    .rst_n_c_slow   (rst_n_c_slow),
    .i_start        (i_start),
    .i_exit         (i_exit),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_work_valid   (o_work_valid),
    .i_work_ready   (i_work_ready),
    .o_work_data    (o_work_data),
    .o_work_nonce   (o_work_nonce),
    .i_result_valid (i_result_valid),
    .o_result_ready (o_result_ready),
    .i_result_data  (i_result_data),
    .i_csr_addr     (i_csr_addr),
    .o_csr_rdata    (o_csr_rdata)
  );

  //////////////////////////////////////////////////
  // watchdogs
  //////////////////////////////////////////////////

  // stop at the first assertion failure
  always @(posedge clk_slow) begin
    if (dut.u_props.err_seen) begin
      $display("*** FAILED ***");
      $fatal(1, "assertion failure reported by the property checker");
    end
  end

  // cycle limit
  initial cycle_cnt = 0;
  always @(posedge clk_slow) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("*** FAILED ***");
      $fatal(1, "timeout after %0d cycles", cycle_cnt);
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk_slow);
    #10;
  endtask

  // fresh random 256 bit result word
  task automatic randomize_result();
    for (int w = 0; w < RESULT_W / 32; w++) begin
      i_result_data[w*32 +: 32] = $urandom;
    end
  endtask

  initial begin
    i_start        = 1'b0;
    i_exit         = 1'b0;
    i_work_ready   = 1'b0;
    i_result_valid = 1'b0;
    i_result_data  = '0;
    i_csr_addr     = '0;
    void'($urandom(93883));

    // idle window after reset
    @(negedge rst_n_c_slow);
    repeat (3) next_cycle();

    i_start = 1'b1;
    next_cycle();
    i_start = 1'b0;

    // first work item
    while (!o_work_valid) begin
      next_cycle();
    end

    // engine model, random stalls and results
    for (int c = 0; c < STIM_CYCLES; c++) begin
      i_work_ready   = ($urandom % 4) != 0;
      i_result_valid = ($urandom % 3) == 0;
      randomize_result();
      next_cycle();
    end
    i_work_ready   = 1'b0;
    i_result_valid = 1'b0;

    // exit held through the readback
    i_exit = 1'b1;
    while (o_busy) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    // status sweep
    for (int a = 0; a < 4; a++) begin
      i_csr_addr = a[CSR_ADDR_W-1:0];
      repeat (2) next_cycle();
    end

    if (dut.u_props.err_seen) begin
      $display("*** FAILED ***");
      $fatal(1, "assertion failure reported by the property checker");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* harness_props.sv */
// module harness_props: reference counts from the ports and bound assertions on miner_harness_top
`default_nettype none
`timescale 1ns/1ps

module harness_props import miner_pkg::*; (
  input logic                  clk_slow,
  input logic                  rst_n_c_slow,
  input logic                  i_start,
  input logic                  o_busy,
  input logic                  o_done,
  input logic                  o_work_valid,
  input logic                  i_work_ready,
  input logic [BLOCK_W-1:0]    o_work_data,
  input logic [NONCE_W-1:0]    o_work_nonce,
  input logic                  i_result_valid,
  input logic                  o_result_ready,
  input logic [RESULT_W-1:0]   i_result_data,
  input logic [CSR_ADDR_W-1:0] i_csr_addr,
  input logic [CSR_W-1:0]      o_csr_rdata
);

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  logic               err_seen;
  logic               started_q;
  logic [CNT_W-1:0]   work_cnt_q;
  logic [CNT_W-1:0]   res_cnt_q;
  logic [CNT_W-1:0]   cyc_q;
  logic [CNT_W-1:0]   lat_q;
  logic               first_q;
  logic [CSR_W-1:0]   last_q;
  logic [2:0]         done_d_q;
  logic               done_seen_q;
  logic [1:0]         post_q;
  logic               hold_q;
  logic [BLOCK_W-1:0] prev_data_q;
  logic [NONCE_W-1:0] prev_nonce_q;
  logic               csr_final;
  logic [CSR_W-1:0]   csr_exp;

  // block as the rule defines it
  // transmission byte 0 is the top byte of the raw template
  function automatic logic [BLOCK_W-1:0] expected_block(input logic [NONCE_W-1:0] nonce);
    logic [BLOCK_W-1:0] blk;
    int                 k;
    for (int b = 0; b < BLOCK_BYTES; b++) begin
      k = b - NONCE_BYTE_POS;
      if (k >= 0 && k < NONCE_W / 8) begin
        blk[b*8 +: 8] = nonce[k*8 +: 8];
      end else begin
        blk[b*8 +: 8] = BLOCK_TEMPLATE_RAW[(BLOCK_BYTES-1-b)*8 +: 8];
      end
    end
    return blk;
  endfunction

  initial err_seen = 1'b0;

  // counts follow the port transfers, cleared by the start command
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow || i_start) begin
      started_q  <= started_q & ~rst_n_c_slow | i_start & ~rst_n_c_slow;
      work_cnt_q <= '0;
      res_cnt_q  <= '0;
      cyc_q      <= '0;
      lat_q      <= '0;
      first_q    <= 1'b0;
      last_q     <= '0;
    end else begin
      if (o_work_valid && i_work_ready) begin
        work_cnt_q <= work_cnt_q + 1'b1;
      end
      // run cycles counted from the first valid cycle
      if (o_work_valid) begin
        cyc_q <= cyc_q + 1'b1;
      end
      if (i_result_valid && o_result_ready) begin
        res_cnt_q <= res_cnt_q + 1'b1;
        last_q    <= i_result_data[CSR_W-1:0];
        if (!first_q) begin
          lat_q   <= cyc_q;
          first_q <= 1'b1;
        end
      end
    end
  end

  // exit tracking and stall history
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      done_d_q    <= '0;
      done_seen_q <= 1'b0;
      post_q      <= '0;
      hold_q      <= 1'b0;
    end else begin
      done_d_q <= {done_d_q[1:0], o_done};
      if (o_done) begin
        done_seen_q <= 1'b1;
      end
      // saturating count of cycles with busy low after done
      if (done_seen_q && !o_busy && post_q != 2'd3) begin
        post_q <= post_q + 1'b1;
      end
      hold_q <= o_work_valid & ~i_work_ready;
    end
    prev_data_q  <= o_work_data;
    prev_nonce_q <= o_work_nonce;
  end

  assign csr_final = (post_q == 2'd3);

  // readback expected for the current address
  assign csr_exp =
    (i_csr_addr == CSR_COUNTS)  ? {res_cnt_q[STAT_W-1:0], work_cnt_q[STAT_W-1:0]} :
    (i_csr_addr == CSR_CYCLES)  ? cyc_q :
    (i_csr_addr == CSR_LATENCY) ? lat_q : last_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_idle: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    !started_q |-> !o_busy && !o_done && !o_work_valid && !o_result_ready)
    else begin
      err_seen = 1'b1;
      $error("outputs active before the start command");
    end

  a_hold_data: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    hold_q |-> o_work_data == prev_data_q)
    else begin
      err_seen = 1'b1;
      $error("FAILED o_work_data got %h exp %h", $sampled(o_work_data),
             $sampled(prev_data_q));
    end

  a_hold_nonce: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    hold_q |-> o_work_nonce == prev_nonce_q)
    else begin
      err_seen = 1'b1;
      $error("FAILED o_work_nonce got %h exp %h", $sampled(o_work_nonce),
             $sampled(prev_nonce_q));
    end

  a_nonce: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    o_work_valid |-> o_work_nonce == work_cnt_q)
    else begin
      err_seen = 1'b1;
      $error("FAILED o_work_nonce got %h exp %h", $sampled(o_work_nonce),
             $sampled(work_cnt_q));
    end

  a_data: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    o_work_valid |-> o_work_data == expected_block(o_work_nonce))
    else begin
      err_seen = 1'b1;
      $error("FAILED o_work_data got %h exp %h", $sampled(o_work_data),
             expected_block($sampled(o_work_nonce)));
    end

  // one cycle done, busy already gone the cycle after
  a_done: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    done_d_q[0] |-> !o_done && !o_busy)
    else begin
      err_seen = 1'b1;
      $error("done longer than one cycle or busy still set after done");
    end

  a_stop: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    done_d_q[2] |-> !o_work_valid && !o_result_ready)
    else begin
      err_seen = 1'b1;
      $error("work valid or result ready still high 3 cycles after done");
    end

  a_csr: assert property (@(posedge clk_slow) disable iff (rst_n_c_slow)
    csr_final |-> o_csr_rdata == csr_exp)
    else begin
      err_seen = 1'b1;
      $error("FAILED o_csr_rdata at addr %h got %h exp %h", $sampled(i_csr_addr),
             $sampled(o_csr_rdata), $sampled(csr_exp));
    end

endmodule

bind miner_harness_top harness_props u_props (.*);

`default_nettype wire

/* tb_clock.sv */
// module tb_clock: testbench clock and power-on reset
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_slow,
  output logic rst_n_c_slow
);

  // free running clock
  initial begin
    clk_slow = 1'b0;
    forever #(PERIOD_NS / 2) clk_slow = ~clk_slow;
  end

  // reset high for the first cycles, released off the edge
  initial begin
    rst_n_c_slow = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_slow);
    #10;
    rst_n_c_slow = 1'b0;
  end

endmodule

`default_nettype wire

/* miner_harness_top.sv */
// module miner_harness_top: run control, work source and perf monitor around an external engine
`default_nettype none
`timescale 1ns/1ps

module miner_harness_top import miner_pkg::*; (
  input  logic                  clk_slow,
  input  logic                  rst_n_c_slow,

  // host command and status
  input  logic                  i_start,
  input  logic                  i_exit,
  output logic                  o_busy,
  output logic                  o_done,

  // work channel to the engine
  output logic                  o_work_valid,
  input  logic                  i_work_ready,
  output logic [BLOCK_W-1:0]    o_work_data,
  output logic [NONCE_W-1:0]    o_work_nonce,

  // result channel from the engine
  input  logic                  i_result_valid,
  output logic                  o_result_ready,
  input  logic [RESULT_W-1:0]   i_result_data,

  // status readback
  input  logic [CSR_ADDR_W-1:0] i_csr_addr,
  output logic [CSR_W-1:0]      o_csr_rdata
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  logic run;
  logic start_pulse;
  logic exit_cmd;
  logic work_valid;
  logic work_fire;

  // transfer on the work channel
  assign work_fire    = work_valid & i_work_ready;
  assign o_work_valid = work_valid;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  run_control u_run_control (
    .clk_slow      (clk_slow),
    .rst_n_c_slow  (rst_n_c_slow),
    .i_start       (i_start),
    .i_exit        (i_exit),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_run         (run),
    .o_start_pulse (start_pulse),
    .o_exit        (exit_cmd)
  );

  //////////////////////////////////////////////////
  // work generation
  //////////////////////////////////////////////////

  work_source u_work_source (
    .clk_slow      (clk_slow),
    .rst_n_c_slow  (rst_n_c_slow),
    .i_run         (run),
    .i_start_pulse (start_pulse),
    .o_work_valid  (work_valid),
    .i_work_ready  (i_work_ready),
    .o_work_data   (o_work_data),
    .o_work_nonce  (o_work_nonce)
  );

  //////////////////////////////////////////////////
  // statistics and csr
  //////////////////////////////////////////////////

  perf_monitor u_perf_monitor (
    .clk_slow       (clk_slow),
    .rst_n_c_slow   (rst_n_c_slow),
    .i_run          (run),
    .i_start_pulse  (start_pulse),
    .i_exit         (exit_cmd),
    .i_work_fire    (work_fire),
    .i_result_valid (i_result_valid),
    .i_result_data  (i_result_data),
    .o_result_ready (o_result_ready),
    .i_csr_addr     (i_csr_addr),
    .o_csr_rdata    (o_csr_rdata)
  );

endmodule

`default_nettype wire

/* perf_monitor.sv */
// module perf_monitor: event and cycle counters, first-result latency, exit snapshot, csr read
`default_nettype none
`timescale 1ns/1ps

module perf_monitor import miner_pkg::*; (
  input  logic                  clk_slow,
  input  logic                  rst_n_c_slow,
  input  logic                  i_run,
  input  logic                  i_start_pulse,
  input  logic                  i_exit,
  input  logic                  i_work_fire,
  input  logic                  i_result_valid,
  input  logic [RESULT_W-1:0]   i_result_data,
  output logic                  o_result_ready,
  input  logic [CSR_ADDR_W-1:0] i_csr_addr,
  output logic [CSR_W-1:0]      o_csr_rdata
);

  //////////////////////////////////////////////////
  // result channel
  //////////////////////////////////////////////////

  logic result_fire;

  // no back pressure on results while running
  assign o_result_ready = i_run;
  assign result_fire    = i_result_valid & i_run;

  //////////////////////////////////////////////////
  // live counters
  //////////////////////////////////////////////////

  logic [CNT_W-1:0] issued_q;
  logic [CNT_W-1:0] retired_q;
  logic [CNT_W-1:0] cycles_q;
  logic [CNT_W-1:0] latency_q;
  logic             first_seen_q;
  logic [CSR_W-1:0] last_result_q;

  // start pulse clears everything for a new run
  // counters freeze once run falls
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow || i_start_pulse) begin
      issued_q  <= '0;
      retired_q <= '0;
      cycles_q  <= '0;
    end else begin
      if (i_work_fire) begin
        issued_q <= issued_q + 1'b1;
      end
      if (result_fire) begin
        retired_q <= retired_q + 1'b1;
      end
      // zero in the first valid cycle, then one per run cycle
      if (i_run) begin
        cycles_q <= cycles_q + 1'b1;
      end
    end
  end

  // latency taken at the first result only
  // flag needed since the count may be zero there
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow || i_start_pulse) begin
      latency_q    <= '0;
      first_seen_q <= 1'b0;
    end else if (result_fire && !first_seen_q) begin
      latency_q    <= cycles_q;
      first_seen_q <= 1'b1;
    end
  end

  // low word of the most recent result
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow || i_start_pulse) begin
      last_result_q <= '0;
    end else if (result_fire) begin
      last_result_q <= i_result_data[CSR_W-1:0];
    end
  end

  //////////////////////////////////////////////////
  // exit snapshot
  //////////////////////////////////////////////////

  logic [CSR_W-1:0] snap_counts_q;
  logic [CSR_W-1:0] snap_cycles_q;
  logic [CSR_W-1:0] snap_latency_q;
  logic [CSR_W-1:0] snap_last_q;

  // reloaded every cycle exit stays high
  // settles a few cycles after run drops
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      snap_counts_q  <= '0;
      snap_cycles_q  <= '0;
      snap_latency_q <= '0;
      snap_last_q    <= '0;
    end else if (i_exit) begin
      // retired on top, issued below
      snap_counts_q  <= {retired_q[STAT_W-1:0], issued_q[STAT_W-1:0]};
      snap_cycles_q  <= cycles_q;
      snap_latency_q <= latency_q;
      snap_last_q    <= last_result_q;
    end
  end

  //////////////////////////////////////////////////
  // csr readback
  //////////////////////////////////////////////////

  // plain mux on the address, no read strobe
  always_comb begin
    case (i_csr_addr)
      CSR_COUNTS:      o_csr_rdata = snap_counts_q;
      CSR_CYCLES:      o_csr_rdata = snap_cycles_q;
      CSR_LATENCY:     o_csr_rdata = snap_latency_q;
      CSR_LAST_RESULT: o_csr_rdata = snap_last_q;
      default:         o_csr_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* work_source.sv */
// module work_source: nonce counter, template byte reversal, nonce insertion, work valid/ready
`default_nettype none
`timescale 1ns/1ps

module work_source import miner_pkg::*; (
  input  logic               clk_slow,
  input  logic               rst_n_c_slow,
  input  logic               i_run,
  input  logic               i_start_pulse,
  output logic               o_work_valid,
  input  logic               i_work_ready,
  output logic [BLOCK_W-1:0] o_work_data,
  output logic [NONCE_W-1:0] o_work_nonce
);

  //////////////////////////////////////////////////
  // block template
  //////////////////////////////////////////////////

  // template in block byte order
  logic [BLOCK_W-1:0] block_tpl;

  // transmission byte 0 sits at the top of the literal
  // block byte 0 sits at the bottom of the bus
  for (genvar i = 0; i < BLOCK_BYTES; i++) begin : g_rev
    assign block_tpl[i*8 +: 8] = BLOCK_TEMPLATE_RAW[(BLOCK_BYTES-1-i)*8 +: 8];
  end

  //////////////////////////////////////////////////
  // nonce and valid
  //////////////////////////////////////////////////

  logic [NONCE_W-1:0] nonce_q;
  logic               valid_q;
  logic               work_valid;
  logic               work_fire;

  // armed one cycle after run, so low in the start pulse cycle
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_run;
    end
  end

  // drops together with run on exit
  assign work_valid = valid_q & i_run;
  assign work_fire  = work_valid & i_work_ready;

  // one item in flight, next nonce on each transfer
  // held while the engine stalls
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      nonce_q <= '0;
    end else if (i_start_pulse) begin
      nonce_q <= '0;
    end else if (work_fire) begin
      nonce_q <= nonce_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // nonce insertion
  //////////////////////////////////////////////////

  // bytes 39..42 carry the nonce, lsb first
  always_comb begin
    o_work_data = block_tpl;
    o_work_data[NONCE_BYTE_POS*8 +: NONCE_W] = nonce_q;
  end

  assign o_work_nonce = nonce_q;
  assign o_work_valid = work_valid;

endmodule

`default_nettype wire

/* run_control.sv */
// module run_control: busy flag, start synchroniser, start pulse, exit register, done pulse
`default_nettype none
`timescale 1ns/1ps

module run_control (
  input  logic clk_slow,
  input  logic rst_n_c_slow,
  input  logic i_start,
  input  logic i_exit,
  output logic o_busy,
  output logic o_done,
  output logic o_run,
  output logic o_start_pulse,
  output logic o_exit
);

  //////////////////////////////////////////////////
  // host command side
  //////////////////////////////////////////////////

  logic       busy_q;
  logic       exit_q;
  logic       exit_d_q;
  logic [1:0] run_sync_q;
  logic       run_d_q;
  logic       done;

  // one pulse on the first cycle of registered exit
  assign done = exit_q & ~exit_d_q;

  // busy set by start, cleared by done
  // done wins if both land together
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow || done) begin
      busy_q <= 1'b0;
    end else if (i_start) begin
      busy_q <= 1'b1;
    end
  end

  // exit command, registered once
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      exit_q   <= 1'b0;
      exit_d_q <= 1'b0;
    end else begin
      exit_q   <= i_exit;
      exit_d_q <= exit_q;
    end
  end

  //////////////////////////////////////////////////
  // run domain
  //////////////////////////////////////////////////

  // two flop sync of busy into run
  always_ff @(posedge clk_slow) begin
    if (rst_n_c_slow) begin
      run_sync_q <= 2'b00;
      run_d_q    <= 1'b0;
    end else begin
      run_sync_q <= {run_sync_q[0], busy_q};
      run_d_q    <= run_sync_q[1];
    end
  end

  assign o_busy        = busy_q;
  assign o_done        = done;
  assign o_run         = run_sync_q[1];
  // rising edge of run clears the statistics
  assign o_start_pulse = run_sync_q[1] & ~run_d_q;
  assign o_exit        = exit_q;

endmodule

`default_nettype wire

/* miner_pkg.sv */
// package: block, nonce and counter widths, block template, csr address map
`default_nettype none

package miner_pkg;

  //////////////////////////////////////////////////
  // work block geometry
  //////////////////////////////////////////////////

  // bytes and bits in one work block
  localparam int BLOCK_BYTES    = 76;
  localparam int BLOCK_W        = BLOCK_BYTES * 8;

  // nonce field, little endian inside the block
  localparam int NONCE_W        = 32;
  localparam int NONCE_BYTE_POS = 39;

  // template in transmission byte order
  // first literal byte is block byte 0
  // bytes 39..42 are zero, overwritten by the nonce
  localparam logic [BLOCK_W-1:0] BLOCK_TEMPLATE_RAW = {
    32'h0E0EF8C1, 32'h9D6B05A4, 32'h27E1B3F0, 32'h6A4C1D92,
    32'hB85E7730, 32'h41F2C9AD, 32'h0C93E51B, 32'hD47A2866,
    32'h5B0F91E3, 32'hA8C63400, 32'h0000007F, 32'h62D5A14C,
    32'hF03B8E29, 32'h97C41A5D, 32'h2E86F0B3, 32'hC15D7A48,
    32'h04B9E26F, 32'h7DA3105C, 32'h8F62CB91
  };

  //////////////////////////////////////////////////
  // engine result
  //////////////////////////////////////////////////

  // hash result width from the engine
  localparam int RESULT_W = 256;

  //////////////////////////////////////////////////
  // statistics and csr map
  //////////////////////////////////////////////////

  // issued, retired and cycle counters
  localparam int CNT_W      = 32;
  // each count packed into csr 0
  localparam int STAT_W     = 16;

  localparam int CSR_W      = 32;
  localparam int CSR_ADDR_W = 2;

  // retired in upper half, issued in lower half
  localparam logic [CSR_ADDR_W-1:0] CSR_COUNTS      = 2'd0;
  // run cycles since first valid work
  localparam logic [CSR_ADDR_W-1:0] CSR_CYCLES      = 2'd1;
  // cycles to first result
  localparam logic [CSR_ADDR_W-1:0] CSR_LATENCY     = 2'd2;
  // low word of last accepted result
  localparam logic [CSR_ADDR_W-1:0] CSR_LAST_RESULT = 2'd3;

endpackage

`default_nettype wire
